// ==== noc_block_window.f ====
+incdir+.
window_cfg_pkg.sv
window_data_pkg.sv
axis_if.sv
window_settings.sv
window_coeff_ram.sv
window_core.sv
noc_block_window.sv
tb_noc_block_window.sv
noc_block_window_props.sv

// ==== noc_block_window_props.sv ====
// Window block stream checks
// Output handshake stability and reset behavior, bound into the top level

`default_nettype none

module noc_block_window_props
  import window_data_pkg::*;
(
  input logic    i_ce_clk,
  input logic    i_reset,
  input sample_t o_tdata,
  input logic    o_tlast,
  input logic    o_tvalid,
  input logic    i_tready
);

  // Output valid cleared once reset is seen on an edge
  reset_clears_valid: assert property (@(posedge i_ce_clk) i_reset |=> !o_tvalid)
    else $error("o_tvalid high while in reset");

  // Stalled beat keeps its payload
  stall_holds_data: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_tvalid && !i_tready) |=> ($stable(o_tdata) && $stable(o_tlast)))
    else $error("o_tdata or o_tlast changed while stalled");

  // No beat withdrawn before it transfers
  stall_holds_valid: assert property (@(posedge i_ce_clk) disable iff (i_reset)
    (o_tvalid && !i_tready) |=> o_tvalid)
    else $error("o_tvalid dropped before the beat transferred");

endmodule

`default_nettype wire

// ==== tb_noc_block_window.sv ====
// Window block testbench
// Settings readback, windowing, index wrap, back-pressure and saturation

`default_nettype none

`include "window_defs.svh"

module tb_noc_block_window
  import window_cfg_pkg::*;
  import window_data_pkg::*;
();

  localparam int SEED        = 32'h66e6;
  localparam int TOTAL_BEATS = 3 * 16 + 40 + 5 + 200 + 9;
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + 2000;

  logic      clk = 1'b0;
  logic      i_reset;
  logic      i_set_stb;
  set_addr_t i_set_addr;
  set_data_t i_set_data;
  rb_addr_t  i_rb_addr;
  rb_data_t  o_rb_data;
  sample_t   i_tdata;
  logic      i_tlast;
  logic      i_tvalid;
  logic      o_tready;
  sample_t   o_tdata;
  logic      o_tlast;
  logic      o_tvalid;
  logic      i_tready;

  // Testbench model state
  coeff_t    coef_tab [`WIN_MAX_SIZE];
  coeff_t    cq [$];
  sample_t   exp_data [$];
  logic      exp_last [$];
  comp_t     sat_vals [3] = '{16'sh7fff, 16'sh8001, 16'sh8000};
  int        tb_len;
  int        win_pos;
  int        cycle_count = 0;
  bit        random_ready;
  string     test_name;

  noc_block_window dut_i (
    .i_ce_clk (clk),
    .*
  );

  bind noc_block_window noc_block_window_props props_i (
    .i_ce_clk (i_ce_clk),
    .i_reset  (i_reset),
    .o_tdata  (o_tdata),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Q1.15 scaling of one component, round half up, clamp to 16 bits
  function automatic comp_t scale_comp(input comp_t x, input coeff_t c);
    longint prod;
    prod = (longint'(x) * longint'(c) + 64'sd16384) >>> 15;
    if (prod > 32767) prod = 32767;
    if (prod < -32768) prod = -32768;
    return comp_t'(prod);
  endfunction

  function automatic sample_t expect_beat(input sample_t s, input coeff_t c);
    sample_t r;
    r.i = scale_comp(s.i, c);
    r.q = scale_comp(s.q, c);
    return r;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR [%s] data expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR [%s] tlast expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_rb(input string name, input rb_data_t exp, input rb_data_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("ERROR [%s] readback expected %h actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_setting(input set_addr_t addr, input set_data_t data);
    @(negedge clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge clk);
    i_set_stb  = 1'b0;
  endtask

  task automatic set_length(input int n);
    write_setting(`WIN_SR_WINDOW_SIZE, set_data_t'(n));
    tb_len = ((n == 0) || (n > `WIN_MAX_SIZE)) ? `WIN_MAX_SIZE : n;
  endtask

  task automatic read_back(input rb_addr_t addr, input rb_data_t exp);
    @(negedge clk);
    i_rb_addr = addr;
    #1;
    check_rb(test_name, exp, o_rb_data);
  endtask

  // Loads from table entry 0, last write closes the load
  task automatic load_coeffs(input coeff_t c [$]);
    for (int k = 0; k < c.size(); k++) begin
      coef_tab[k] = c[k];
      write_setting((k == c.size() - 1) ? `WIN_SR_COEFF_LAST : `WIN_SR_COEFF_BASE,
                    set_data_t'(c[k]));
    end
  endtask

  // Holds one beat until the DUT takes it, then queues the expected output
  task automatic push_beat(input sample_t d, input logic last, input bit gaps);
    @(negedge clk);
    while (gaps && ($urandom % 2 == 0)) begin
      i_tvalid = 1'b0;
      @(negedge clk);
    end
    i_tdata  = d;
    i_tlast  = last;
    i_tvalid = 1'b1;
    #1;
    while (!o_tready) begin
      @(negedge clk);
      #1;
    end
    exp_data.push_back(expect_beat(d, coef_tab[win_pos]));
    exp_last.push_back(last);
    win_pos = (last || (win_pos == tb_len - 1)) ? 0 : win_pos + 1;
  endtask

  task automatic end_stream();
    @(negedge clk);
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output ready, monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    i_tready = random_ready ? ($urandom % 2 == 1) : 1'b1;
  end

  // Inputs settle mid-cycle, so this beat moves on the next rising edge
  always @(negedge clk) begin
    #2;
    if ((o_tvalid === 1'b1) && (i_tready === 1'b1)) begin
      if (exp_data.size() == 0) begin
        stop_with_error($sformatf("Output beat in test %s with no beat expected", test_name));
      end else begin
        check_sample(test_name, exp_data.pop_front(), o_tdata);
        check_last(test_name, exp_last.pop_front(), o_tlast);
      end
    end
    // Input side stalls only behind a full, blocked output stage
    if (!i_reset && (o_tready !== 1'b1) &&
        !((o_tvalid === 1'b1) && (i_tready === 1'b0))) begin
      stop_with_error($sformatf("Input ready low in test %s with the output stage free",
                                test_name));
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_error($sformatf("Run hung in test %s, no progress after %0d cycles",
                                test_name, cycle_count));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    i_reset      = 1'b1;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_rb_addr    = '0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_tvalid     = 1'b0;
    i_tready     = 1'b1;
    random_ready = 1'b0;
    tb_len       = `WIN_MAX_SIZE;
    win_pos      = 0;
    repeat (4) @(negedge clk);
    i_reset = 1'b0;

    test_name = "readback";
    read_back(8'd0, 64'd4096);
    read_back(8'd1, 64'd4096);
    read_back(8'd7, `WIN_RB_BAD);
    set_length(16);
    read_back(8'd1, 64'd16);
    set_length(0);
    read_back(8'd1, 64'd4096);

    test_name = "full_rate";
    repeat (16) cq.push_back(coeff_t'($urandom));
    load_coeffs(cq);
    set_length(16);
    for (int k = 0; k < 3 * 16; k++) begin
      push_beat(sample_t'($urandom), (k % 16) == 15, 1'b0);
    end
    end_stream();
    wait_drain();

    // 40 beats wrap at the length, tlast then restarts the index early
    test_name = "index_wrap";
    for (int k = 0; k < 45; k++) begin
      push_beat(sample_t'($urandom), k == 44, 1'b0);
    end
    end_stream();
    wait_drain();

    test_name = "back_pressure";
    random_ready = 1'b1;
    for (int k = 0; k < 200; k++) begin
      push_beat(sample_t'($urandom), (k == 199) || ($urandom % 8 == 0), 1'b1);
    end
    end_stream();
    wait_drain();
    random_ready = 1'b0;

    test_name = "round_saturate";
    cq = '{16'sh8000, 16'sh7fff, 16'sh0001};
    load_coeffs(cq);
    set_length(3);
    for (int k = 0; k < 9; k++) begin
      push_beat(sample_t'({sat_vals[k / 3], sat_vals[(k / 3 + 1) % 3]}), (k % 3) == 2, 1'b0);
    end
    end_stream();
    wait_drain();

    if (exp_data.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_error("Expected output beats still outstanding at end of run");
    end
  end

endmodule

`default_nettype wire

// ==== noc_block_window.sv ====
// Window block top level
// Settings decoder and window core behind plain stream and settings ports

`default_nettype none

module noc_block_window
  import window_cfg_pkg::*;
  import window_data_pkg::*;
(
  input  logic      i_ce_clk,
  input  logic      i_reset,
  // Settings bus
  input  logic      i_set_stb,
  input  set_addr_t i_set_addr,
  input  set_data_t i_set_data,
  // Readback
  input  rb_addr_t  i_rb_addr,
  output rb_data_t  o_rb_data,
  // Sample input stream
  input  sample_t   i_tdata,
  input  logic      i_tlast,
  input  logic      i_tvalid,
  output logic      o_tready,
  // Sample output stream
  output sample_t   o_tdata,
  output logic      o_tlast,
  output logic      o_tvalid,
  input  logic      i_tready
);

  win_len_t win_len;

  // Coefficient load path
  axis_if #(.T(coeff_t)) coeff_s ();

  window_settings settings_i (
    .i_ce_clk   (i_ce_clk),
    .i_reset    (i_reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .o_win_len  (win_len),
    .coeff_s    (coeff_s.mst)
  );

  window_core core_i (
    .i_ce_clk  (i_ce_clk),
    .i_reset   (i_reset),
    .i_win_len (win_len),
    .coeff_s   (coeff_s.slv),
    .i_tdata   (i_tdata),
    .i_tlast   (i_tlast),
    .i_tvalid  (i_tvalid),
    .o_tready  (o_tready),
    .o_tdata   (o_tdata),
    .o_tlast   (o_tlast),
    .o_tvalid  (o_tvalid),
    .i_tready  (i_tready)
  );

endmodule

`default_nettype wire

// ==== window_core.sv ====
// Window core
// Scales each complex sample by the coefficient for its window position,
// three register stages with stall on output back-pressure

`default_nettype none

module window_core
  import window_data_pkg::*;
(
  input  logic     i_ce_clk,
  input  logic     i_reset,
  input  win_len_t i_win_len,
  axis_if.slv      coeff_s,
  // Sample input
  input  sample_t  i_tdata,
  input  logic     i_tlast,
  input  logic     i_tvalid,
  output logic     o_tready,
  // Sample output
  output sample_t  o_tdata,
  output logic     o_tlast,
  output logic     o_tvalid,
  input  logic     i_tready
);

  typedef logic signed [31:0] prod_t;

  // Round half up at bit 14, then clamp to the component range
  function automatic comp_t round_sat(input prod_t prod);
    prod_t rounded;
    rounded = (prod + 32'sd16384) >>> 15;
    if (rounded > 32'sd32767) begin
      return 16'sh7fff;
    end else if (rounded < -32'sd32768) begin
      return 16'sh8000;
    end
    return rounded[COMP_W-1:0];
  endfunction

  logic     advance;
  logic     in_xfer;
  logic     coeff_xfer;
  logic     samp_wrap;
  win_idx_t wr_idx;
  win_idx_t samp_idx;
  win_idx_t rd_idx;

  // Stage 1, sample waiting on its coefficient
  win_idx_t s1_idx;
  coeff_t   s1_coeff;
  sample_t  s1_data;
  logic     s1_last;
  logic     s1_valid;

  // Stage 2, full-precision products
  prod_t    s2_prod_i;
  prod_t    s2_prod_q;
  logic     s2_last;
  logic     s2_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Coefficient table load
  ////////////////////////////////////////////////////////////////////////////

  // Table write never stalls
  assign coeff_s.tready = 1'b1;
  assign coeff_xfer     = coeff_s.tvalid && coeff_s.tready;

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      wr_idx <= '0;
    end else if (coeff_xfer) begin
      wr_idx <= coeff_s.tlast ? '0 : wr_idx + 1'b1;
    end
  end

  // On a stall the held stage 1 index is read again, so its coefficient stays put
  assign rd_idx = advance ? samp_idx : s1_idx;

  window_coeff_ram coeff_ram_i (
    .i_ce_clk   (i_ce_clk),
    .i_wr_en    (coeff_xfer),
    .i_wr_idx   (wr_idx),
    .i_wr_coeff (coeff_s.tdata),
    .i_rd_idx   (rd_idx),
    .o_rd_coeff (s1_coeff)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Sample position in the window
  ////////////////////////////////////////////////////////////////////////////

  assign advance   = !o_tvalid || i_tready;
  assign o_tready  = advance;
  assign in_xfer   = i_tvalid && advance;
  assign samp_wrap = i_tlast || ({1'b0, samp_idx} == (i_win_len - 1'b1));

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      samp_idx <= '0;
    end else if (in_xfer) begin
      samp_idx <= samp_wrap ? '0 : samp_idx + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      o_tvalid <= 1'b0;
    end else if (advance) begin
      s1_valid <= i_tvalid;
      s2_valid <= s1_valid;
      o_tvalid <= s2_valid;
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (advance) begin
      s1_idx    <= samp_idx;
      s1_data   <= i_tdata;
      s1_last   <= i_tlast;
      // Signed 16x16 into 32 bits
      s2_prod_i <= s1_data.i * s1_coeff;
      s2_prod_q <= s1_data.q * s1_coeff;
      s2_last   <= s1_last;
      o_tdata.i <= round_sat(s2_prod_i);
      o_tdata.q <= round_sat(s2_prod_q);
      o_tlast   <= s2_last;
    end
  end

endmodule

`default_nettype wire

// ==== window_coeff_ram.sv ====
// Window coefficient table
// Single write port from the coefficient stream, one-cycle registered read

`default_nettype none

`include "window_defs.svh"

module window_coeff_ram
  import window_data_pkg::*;
(
  input  logic     i_ce_clk,
  // Write side
  input  logic     i_wr_en,
  input  win_idx_t i_wr_idx,
  input  coeff_t   i_wr_coeff,
  // Read side
  input  win_idx_t i_rd_idx,
  output coeff_t   o_rd_coeff
);

  // Table storage, maps to block RAM
  coeff_t coeff_mem [`WIN_MAX_SIZE];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_wr_en) begin
      coeff_mem[i_wr_idx] <= i_wr_coeff;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Old data on a same-address collision
  always_ff @(posedge i_ce_clk) begin
    o_rd_coeff <= coeff_mem[i_rd_idx];
  end

endmodule

`default_nettype wire

// ==== window_settings.sv ====
// Window settings decoder
// Turns settings writes into the window length and the coefficient stream,
// and serves the readback registers

`default_nettype none

`include "window_defs.svh"

module window_settings
  import window_cfg_pkg::*;
  import window_data_pkg::*;
(
  input  logic      i_ce_clk,
  input  logic      i_reset,
  input  logic      i_set_stb,
  input  set_addr_t i_set_addr,
  input  set_data_t i_set_data,
  input  rb_addr_t  i_rb_addr,
  output rb_data_t  o_rb_data,
  output win_len_t  o_win_len,
  axis_if.mst       coeff_s
);

  logic     coeff_wr;
  logic     coeff_last_wr;
  logic     len_wr;
  logic     load_end;
  win_idx_t load_ptr;
  win_len_t win_len;

  // Address decode
  assign coeff_last_wr = i_set_stb && (i_set_addr == `WIN_SR_COEFF_LAST);
  assign coeff_wr      = (i_set_stb && (i_set_addr == `WIN_SR_COEFF_BASE)) || coeff_last_wr;
  assign len_wr        = i_set_stb && (i_set_addr == `WIN_SR_WINDOW_SIZE);

  // Load closes on the last address or when the table is full
  assign load_end = coeff_last_wr || (load_ptr == win_idx_t'(`WIN_MAX_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Window length, 0 and oversize values become the full table
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      win_len <= win_len_t'(`WIN_MAX_SIZE);
    end else if (len_wr) begin
      if ((i_set_data == '0) || (i_set_data > set_data_t'(`WIN_MAX_SIZE))) begin
        win_len <= win_len_t'(`WIN_MAX_SIZE);
      end else begin
        win_len <= i_set_data[$bits(win_len_t)-1:0];
      end
    end
  end

  assign o_win_len = win_len;

  ////////////////////////////////////////////////////////////////////////////
  // Coefficient stream
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_reset) begin
      load_ptr       <= '0;
      coeff_s.tvalid <= 1'b0;
    end else if (coeff_wr) begin
      load_ptr       <= load_end ? '0 : load_ptr + 1'b1;
      coeff_s.tvalid <= 1'b1;
    end else if (coeff_s.tready) begin
      coeff_s.tvalid <= 1'b0;
    end
  end

  // Beat payload
  always_ff @(posedge i_ce_clk) begin
    if (coeff_wr) begin
      coeff_s.tdata <= coeff_t'(i_set_data[`WIN_COEFF_WIDTH-1:0]);
      coeff_s.tlast <= load_end;
    end
  end

  // Readback mux
  always_comb begin
    case (rb_sel_e'(i_rb_addr))
      RB_MAX_SIZE:    o_rb_data = rb_data_t'(`WIN_MAX_SIZE);
      RB_WINDOW_SIZE: o_rb_data = rb_data_t'(win_len);
      default:        o_rb_data = `WIN_RB_BAD;
    endcase
  end

endmodule

`default_nettype wire

// ==== axis_if.sv ====
// Stream interface
// Valid/ready/last handshake with a payload type chosen per instance

`default_nettype none

interface axis_if #(
  parameter type T = logic [31:0]
) ();

  T     tdata;
  logic tlast;
  logic tvalid;
  logic tready;

  // Beat moves on an edge with tvalid and tready both high
  modport mst (
    output tdata,
    output tlast,
    output tvalid,
    input  tready
  );

  modport slv (
    input  tdata,
    input  tlast,
    input  tvalid,
    output tready
  );

endinterface

`default_nettype wire

// ==== window_data_pkg.sv ====
// Window datapath package
// Sample, coefficient, table index and window length types

`default_nettype none

`include "window_defs.svh"

package window_data_pkg;

  localparam int COMP_W = 16;

  // One I or Q component
  typedef logic signed [COMP_W-1:0] comp_t;

  // I in the upper half, Q in the lower half
  typedef struct packed {
    comp_t i;
    comp_t q;
  } sample_t;

  // Q1.15 window coefficient
  typedef logic signed [`WIN_COEFF_WIDTH-1:0] coeff_t;

  typedef logic [`WIN_MAX_LOG2_SIZE-1:0] win_idx_t;

  // One extra bit so the full table length fits
  typedef logic [`WIN_MAX_LOG2_SIZE:0] win_len_t;

endpackage

`default_nettype wire

// ==== window_cfg_pkg.sv ====
// Window settings package
// Types for the settings bus and the readback port

`default_nettype none

package window_cfg_pkg;

  // Settings bus fields
  typedef logic [7:0]  set_addr_t;
  typedef logic [31:0] set_data_t;

  // Readback port fields
  typedef logic [7:0]  rb_addr_t;
  typedef logic [63:0] rb_data_t;

  // Readback selector
  typedef enum logic [7:0] {
    RB_MAX_SIZE    = 8'd0,
    RB_WINDOW_SIZE = 8'd1
  } rb_sel_e;

endpackage

`default_nettype wire

// ==== window_defs.svh ====
// Window block constants
// Settings register map, coefficient table depth and coefficient width

`ifndef WINDOW_DEFS_SVH
`define WINDOW_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Settings bus register map
////////////////////////////////////////////////////////////////////////////

// One coefficient per write, load pointer advances
`define WIN_SR_COEFF_BASE 8'd129
// Final coefficient, closes the load
`define WIN_SR_COEFF_LAST 8'd130
`define WIN_SR_WINDOW_SIZE 8'd131

////////////////////////////////////////////////////////////////////////////
// Table geometry
////////////////////////////////////////////////////////////////////////////

`define WIN_MAX_LOG2_SIZE 12
`define WIN_MAX_SIZE 4096
// Q1.15 coefficients
`define WIN_COEFF_WIDTH 16

// Filler for unmapped readback addresses
`define WIN_RB_BAD 64'h0BAD_C0DE_0BAD_C0DE

`endif
